/* bench/soc_sva.sv */
`timescale 1ns/1ns

module soc_sva (
    input logic clk_rv,
    input logic rst_rv,
    input logic mem_valid,
    input logic mem_ready,
    input logic led_red_n,
    input logic led_green_n,
    input logic usb_rst_n
);

    // ---------------------------------------------------------------------------
    // Bus handshake
    // ---------------------------------------------------------------------------

    a_ready_with_valid: assert property (
        @(posedge clk_rv) disable iff (!rst_rv) mem_ready |-> mem_valid
    ) else $error("mem_ready high without mem_valid");

    a_ready_single: assert property (
        @(posedge clk_rv) disable iff (!rst_rv) mem_ready |=> !mem_ready
    ) else $error("mem_ready held for more than one cycle");

    // Outputs settle one edge into reset
    a_reset_outputs: assert property (
        @(posedge clk_rv) !rst_rv |=> (led_red_n && led_green_n && !usb_rst_n)
    ) else $error("LED or USB reset output not at reset value during reset");

endmodule

bind soc_fabric_top soc_sva i_soc_sva (
    .clk_rv      (clk_rv),
    .rst_rv      (rst_rv),
    .mem_valid   (mem_valid),
    .mem_ready   (mem_ready),
    .led_red_n   (led_red_n),
    .led_green_n (led_green_n),
    .usb_rst_n   (usb_rst_n)
);

/* bench/tb_soc.sv */
`timescale 1ns/1ns

module tb_soc;

    localparam int          CLKS_PER_BIT  = 4;
    localparam int          BUS_TIMEOUT   = 200;
    localparam int          FRAME_TIMEOUT = 2000;
    localparam logic [31:0] SEED          = 32'h6be85eeb;
    localparam logic [31:0] RAM_BASE      = 32'hFFFF_0000;
    localparam logic [31:0] GPIO_BASE     = 32'h0300_0000;
    localparam logic [31:0] UART_ADDR     = 32'h0300_0100;
    localparam logic [31:0] DDR_ADDR      = 32'h0C00_0000;
    localparam logic [4:0]  DELAY_IN      = 5'h13;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] rdata;
        logic        irq;
    } entry_t;

    logic        clk_rv;
    logic        rst_rv;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        irq;
    logic [4:0]  delay_sel_in;
    logic [4:0]  delay_sel_out;
    logic        led_red_n;
    logic        led_green_n;
    logic        scl;
    logic        sda_oe;
    logic        usb_rst_n;
    logic        txd;
    logic        sda_in;

    entry_t      stim[$];
    logic [7:0]  exp_bytes[$];
    logic [7:0]  rx_bytes[$];
    logic [31:0] lfsr_state;
    logic [4:0]  exp_delay_sel;
    int          error_count  = 0;
    int          check_count  = 0;
    int          uart_done    = 0;
    int          frames_ended = 0;
    int          rx_cnt       = 0;
    logic        rx_busy      = 1'b0;
    logic [7:0]  rx_shift;

    soc_fabric_top #(
        .RAM_WORDS    (256),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_dut (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .irq           (irq),
        .delay_sel_in  (delay_sel_in),
        .delay_sel_out (delay_sel_out),
        .led_red_n     (led_red_n),
        .led_green_n   (led_green_n),
        .scl           (scl),
        .sda_oe        (sda_oe),
        .usb_rst_n     (usb_rst_n),
        .txd           (txd),
        .sda_in        (sda_in)
    );

    initial begin
        clk_rv = 1'b0;
        forever #2 clk_rv = ~clk_rv;
    end

    // ---------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] byte_merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] strb);
        logic [31:0] m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return m;
    endfunction

    function automatic void add_entry(input logic [31:0] addr, input logic [31:0] wdata,
                                      input logic [3:0] strb, input logic [31:0] rdata,
                                      input logic exp_irq);
        entry_t e;
        e.addr  = addr;
        e.wdata = wdata;
        e.strb  = strb;
        e.rdata = rdata;
        e.irq   = exp_irq;
        stim.push_back(e);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] %s: got %08h, expected %08h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // One access with latency counted from valid to ready
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output int lat, output logic tx_idle);
        int cycles;
        @(posedge clk_rv);
        tx_idle = !rx_busy;
        mem_valid <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= wdata;
        mem_wstrb <= strb;
        cycles = 0;
        @(negedge clk_rv);
        while (!mem_ready) begin
            if (cycles == BUS_TIMEOUT) begin
                $display("Timeout: no ready for the access to address %08h", addr);
                error_count++;
                end_run();
            end
            @(negedge clk_rv);
            cycles++;
        end
        rdata = mem_rdata;
        lat   = cycles;
        @(posedge clk_rv);
        mem_valid <= 1'b0;
        mem_wstrb <= 4'b0000;
        @(negedge clk_rv);
    endtask

    // ---------------------------------------------------------------------
    // Stimulus table
    // ---------------------------------------------------------------------

    task automatic build_stimulus();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] p0;
        logic [31:0] p1;
        logic [31:0] r;
        w0 = rand_bits(32);
        w1 = rand_bits(32);
        p0 = rand_bits(32);
        p1 = rand_bits(32);
        add_entry(RAM_BASE + 32'h010, w0, 4'hF, 32'h0, 1'b0);
        add_entry(RAM_BASE + 32'h014, w1, 4'hF, 32'h0, 1'b0);
        // 256 words further on alias the same RAM words
        add_entry(RAM_BASE + 32'h410, p0, 4'b0101, 32'h0, 1'b0);
        add_entry(RAM_BASE + 32'h814, p1, 4'b1000, 32'h0, 1'b0);
        add_entry(RAM_BASE + 32'hC10, 32'h0, 4'h0, byte_merge(w0, p0, 4'b0101), 1'b0);
        add_entry(RAM_BASE + 32'h014, 32'h0, 4'h0, byte_merge(w1, p1, 4'b1000), 1'b0);
        // GPIO calibration readback comes first
        add_entry(GPIO_BASE, 32'h0, 4'h0, {27'd0, DELAY_IN}, 1'b0);
        r = rand_bits(32);
        exp_delay_sel = r[4:0];
        add_entry(GPIO_BASE, r, 4'hF, 32'h0, 1'b0);
        r = rand_bits(32);
        add_entry(GPIO_BASE + 32'h04, {r[31:1], 1'b1}, 4'hF, 32'h0, 1'b0);
        add_entry(GPIO_BASE + 32'h08, {r[30:0], 1'b1}, 4'hF, 32'h0, 1'b0);
        add_entry(GPIO_BASE + 32'h14, {r[31:1], 1'b0}, 4'hF, 32'h0, 1'b0);
        add_entry(GPIO_BASE + 32'h18, {r[30:0], 1'b0}, 4'hF, 32'h0, 1'b0);
        add_entry(GPIO_BASE + 32'h1C, {r[29:0], 2'b01}, 4'hF, 32'h0, 1'b0);
        add_entry(GPIO_BASE, 32'h0, 4'h0, {27'd0, DELAY_IN}, 1'b0);
        add_entry(GPIO_BASE + 32'h18, 32'h0, 4'h0, 32'h1, 1'b0);
        add_entry(GPIO_BASE + 32'h0C, 32'h0, 4'h0, 32'h0, 1'b0);
        add_entry(GPIO_BASE + 32'h10, 32'h0, 4'h0, 32'h0, 1'b0);
        add_entry(GPIO_BASE + 32'h04, 32'h0, 4'h0, 32'h0, 1'b0);
        // Later back to back UART writes wait on the frame in progress
        for (int i = 0; i < 3; i++) begin
            add_entry(UART_ADDR, rand_bits(32), 4'hF, 32'h0, 1'b0);
        end
        add_entry(DDR_ADDR, 32'h0, 4'h0, 32'hFFFF_FFFF, 1'b1);
        add_entry(UART_ADDR, rand_bits(32), 4'h0, 32'hFFFF_FFFF, 1'b1);
        add_entry(RAM_BASE + 32'h010, 32'h0, 4'h0, byte_merge(w0, p0, 4'b0101), 1'b1);
    endtask

    // ---------------------------------------------------------------------
    // UART receiver with mid-bit sampling
    // ---------------------------------------------------------------------

    always @(negedge clk_rv) begin
        if (!rst_rv) begin
            rx_busy <= 1'b0;
            rx_cnt  <= 0;
        end else if (!rx_busy) begin
            if (!txd) begin
                rx_busy <= 1'b1;
                rx_cnt  <= 1;
            end
        end else begin
            rx_cnt <= rx_cnt + 1;
            if (rx_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                if (rx_cnt / CLKS_PER_BIT == 0) begin
                    check_value("txd start bit", 32'(txd), 32'h0);
                end else if (rx_cnt / CLKS_PER_BIT == 9) begin
                    check_value("txd stop bit", 32'(txd), 32'h1);
                end else begin
                    rx_shift <= {txd, rx_shift[7:1]};
                end
            end
            // Last cycle of the stop bit
            if (rx_cnt == 10 * CLKS_PER_BIT - 1) begin
                rx_busy      <= 1'b0;
                frames_ended <= frames_ended + 1;
                rx_bytes.push_back(rx_shift);
            end
        end
    end

    // ---------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------

    initial begin
        entry_t      e;
        logic [31:0] rdata;
        int          lat;
        logic        tx_idle;
        logic        is_uart;
        int          wait_cycles;
        rst_rv       = 1'b0;
        mem_valid    = 1'b0;
        mem_addr     = 32'h0;
        mem_wdata    = 32'h0;
        mem_wstrb    = 4'h0;
        delay_sel_in = DELAY_IN;
        sda_in       = 1'b1;
        lfsr_state   = SEED;
        build_stimulus();
        repeat (5) @(posedge clk_rv);
        rst_rv <= 1'b1;
        @(negedge clk_rv);
        check_value("mem_ready", 32'(mem_ready), 32'h0);
        check_value("irq", 32'(irq), 32'h0);
        check_value("txd", 32'(txd), 32'h1);
        check_value("led_red_n", 32'(led_red_n), 32'h1);
        check_value("led_green_n", 32'(led_green_n), 32'h1);
        check_value("scl", 32'(scl), 32'h1);
        check_value("sda_oe", 32'(sda_oe), 32'h0);
        check_value("usb_rst_n", 32'(usb_rst_n), 32'h0);
        check_value("delay_sel_out", 32'(delay_sel_out), 32'(DELAY_IN));

        for (int i = 0; i < stim.size(); i++) begin
            e = stim[i];
            is_uart = (e.addr == UART_ADDR);
            bus_access(e.addr, e.wdata, e.strb, rdata, lat, tx_idle);
            if (!is_uart || tx_idle) begin
                check_value("latency", lat, 32'd2);
            end
            if (e.strb == 4'h0) begin
                check_value("mem_rdata", rdata, e.rdata);
            end
            check_value("irq", 32'(irq), 32'(e.irq));
            if (is_uart) begin
                // Accepted only once every earlier frame has ended
                check_value("frames_ended", frames_ended, uart_done);
                exp_bytes.push_back(e.wdata[7:0]);
                uart_done++;
            end
        end

        wait_cycles = 0;
        while (frames_ended < uart_done) begin
            if (wait_cycles == FRAME_TIMEOUT) begin
                $display("Timeout: UART frames did not all arrive at the receiver");
                error_count++;
                end_run();
            end
            @(negedge clk_rv);
            wait_cycles++;
        end
        check_value("rx_count", rx_bytes.size(), exp_bytes.size());
        for (int i = 0; i < exp_bytes.size() && i < rx_bytes.size(); i++) begin
            check_value("rx_byte", 32'(rx_bytes[i]), 32'(exp_bytes[i]));
        end

        check_value("delay_sel_out", 32'(delay_sel_out), 32'(exp_delay_sel));
        check_value("led_green_n", 32'(led_green_n), 32'h0);
        check_value("led_red_n", 32'(led_red_n), 32'h0);
        check_value("scl", 32'(scl), 32'h0);
        check_value("sda_oe", 32'(sda_oe), 32'h1);
        check_value("usb_rst_n", 32'(usb_rst_n), 32'h1);
        check_value("irq", 32'(irq), 32'h1);
        end_run();
    end

endmodule

/* files.f */
hw/soc_map_pkg.sv
hw/periph_pkg.sv
hw/bus_decoder.sv
hw/soc_ram.sv
hw/gpio_regs.sv
hw/uart_tx.sv
hw/soc_fabric_top.sv
bench/soc_sva.sv
bench/tb_soc.sv

/* hw/bus_decoder.sv */
`timescale 1ns/1ns

module bus_decoder
    import soc_map_pkg::*;
(
    input  logic        clk_rv,
    input  logic        rst_rv,
    input  logic        mem_valid,
    input  bus_addr_u   mem_addr,
    input  logic        ram_ack,
    input  logic        gpio_ack,
    input  logic        uart_ready,
    input  logic [31:0] ram_rdata,
    input  logic [31:0] gpio_rdata,
    output logic        ram_sel,
    output logic        gpio_sel,
    output logic        uart_sel,
    output logic        mem_ready,
    output logic [31:0] mem_rdata,
    output logic        irq
);

    region_e region_d;
    region_e region_q;
    logic    region_vld;
    logic    access;
    logic    none_sel;
    logic    none_ack;

    // ---------------------------------------------------------------------
    // Region decode
    // ---------------------------------------------------------------------

    always_comb begin
        if (mem_addr.parts.page == RAM_PAGE) begin
            region_d = REGION_RAM;
        end else if (mem_addr.flat == {GPIO_PAGE, UART_OFFSET}) begin
            region_d = REGION_UART;
        end else if (mem_addr.parts.page == GPIO_PAGE &&
                     mem_addr.parts.offset <= GPIO_LAST_OFFSET) begin
            region_d = REGION_GPIO;
        end else begin
            region_d = REGION_NONE;
        end
    end

    // Region is sampled one cycle into the access.
    // region_vld keeps a stale region from selecting a slave in cycle 0
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region_q   <= REGION_NONE;
            region_vld <= 1'b0;
            none_ack   <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (mem_valid) begin
                region_q <= region_d;
            end
            region_vld <= mem_valid && !mem_ready;
            none_ack   <= none_sel;
            // Sticky until reset
            if (none_ack) begin
                irq <= 1'b1;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Slave selects and acknowledge
    // ---------------------------------------------------------------------

    assign access   = mem_valid && region_vld;
    assign ram_sel  = access && (region_q == REGION_RAM)  && !ram_ack;
    assign gpio_sel = access && (region_q == REGION_GPIO) && !gpio_ack;
    assign uart_sel = access && (region_q == REGION_UART) && !uart_ready;
    assign none_sel = access && (region_q == REGION_NONE) && !none_ack;

    assign mem_ready = ram_ack || gpio_ack || uart_ready || none_ack;

    // UART is write-only, so it shares the idle value with unmapped space
    always_comb begin
        case (region_q)
            REGION_RAM:  mem_rdata = ram_rdata;
            REGION_GPIO: mem_rdata = gpio_rdata;
            default:     mem_rdata = BUS_IDLE_DATA;
        endcase
    end

endmodule

/* hw/gpio_regs.sv */
`timescale 1ns/1ns

module gpio_regs
    import soc_map_pkg::*;
    import periph_pkg::*;
(
    input  logic                   clk_rv,
    input  logic                   rst_rv,
    input  logic                   gpio_sel,
    input  bus_addr_u              mem_addr,
    input  logic [31:0]            mem_wdata,
    input  logic [3:0]             mem_wstrb,
    input  logic [DELAY_SEL_W-1:0] delay_sel_in,
    input  logic                   sda_in,
    output logic                   gpio_ack,
    output logic [31:0]            gpio_rdata,
    output logic [DELAY_SEL_W-1:0] delay_sel_out,
    output logic                   led_red_n,
    output logic                   led_green_n,
    output logic                   scl,
    output logic                   sda_oe,
    output logic                   usb_rst_n
);

    gpio_reg_e              reg_idx;
    logic                   is_write;
    logic [DELAY_SEL_W-1:0] delay_sel_q;
    logic                   led_green_q;
    logic                   led_red_q;
    logic                   scl_q;
    logic                   sda_q;
    logic                   usb_rst_n_q;

    // Bits 4..2 pick the register, higher offset bits alias
    assign reg_idx  = gpio_reg_e'(mem_addr.parts.offset[4:2]);
    assign is_write = (mem_wstrb != 4'b0000);

    // ---------------------------------------------------------------------
    // Register writes
    // ---------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            gpio_ack    <= 1'b0;
            // Calibration starts from the detected value
            delay_sel_q <= delay_sel_in;
            led_green_q <= LED_RESET;
            led_red_q   <= LED_RESET;
            scl_q       <= SCL_RESET;
            sda_q       <= SDA_RESET;
            usb_rst_n_q <= USB_RST_N_RESET;
        end else begin
            gpio_ack <= gpio_sel;
            if (gpio_sel && is_write) begin
                case (reg_idx)
                    DELAY_SEL: delay_sel_q <= mem_wdata[DELAY_SEL_W-1:0];
                    LED_GREEN: led_green_q <= mem_wdata[0];
                    LED_RED:   led_red_q   <= mem_wdata[0];
                    I2C_SCL:   scl_q       <= mem_wdata[0];
                    I2C_SDA:   sda_q       <= mem_wdata[0];
                    USB_RST_N: usb_rst_n_q <= mem_wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // ---------------------------------------------------------------------
    // Read data
    // ---------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (gpio_sel && !is_write) begin
            case (reg_idx)
                DELAY_SEL: gpio_rdata <= {{(32 - DELAY_SEL_W){1'b0}}, delay_sel_in};
                I2C_SDA:   gpio_rdata <= {31'd0, sda_in};
                default:   gpio_rdata <= 32'd0;
            endcase
        end
    end

    assign delay_sel_out = delay_sel_q;
    // LEDs are active low
    assign led_green_n   = ~led_green_q;
    assign led_red_n     = ~led_red_q;
    assign scl           = scl_q;
    // Open drain, a zero in the register pulls the line down
    assign sda_oe        = ~sda_q;
    assign usb_rst_n     = usb_rst_n_q;

endmodule

/* hw/periph_pkg.sv */
package periph_pkg;

    // ---------------------------------------------------------------------
    // GPIO block
    // ---------------------------------------------------------------------

    // Word index within the GPIO page, 3 and 4 are unused
    typedef enum logic [2:0] {
        DELAY_SEL = 3'd0,
        LED_GREEN = 3'd1,
        LED_RED   = 3'd2,
        I2C_SCL   = 3'd5,
        I2C_SDA   = 3'd6,
        USB_RST_N = 3'd7
    } gpio_reg_e;

    // DDR input delay calibration field
    localparam int DELAY_SEL_W = 5;

    // Register values after reset (LEDs off, I2C released, USB held in reset)
    localparam logic LED_RESET       = 1'b0;
    localparam logic SCL_RESET       = 1'b1;
    localparam logic SDA_RESET       = 1'b1;
    localparam logic USB_RST_N_RESET = 1'b0;

    // ---------------------------------------------------------------------
    // UART frame, 8N1
    // ---------------------------------------------------------------------

    localparam int   UART_DATA_W     = 8;
    localparam int   UART_FRAME_BITS = UART_DATA_W + 2;
    localparam logic UART_START_BIT  = 1'b0;
    localparam logic UART_STOP_BIT   = 1'b1;

endpackage

/* hw/soc_fabric_top.sv */
`timescale 1ns/1ns

module soc_fabric_top #(
    parameter int RAM_WORDS    = 2048,
    parameter int CLKS_PER_BIT = 217
) (
    input  logic        clk_rv,
    input  logic        rst_rv,
    input  logic        mem_valid,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wstrb,
    output logic        mem_ready,
    output logic [31:0] mem_rdata,
    output logic        irq,
    input  logic [4:0]  delay_sel_in,
    output logic [4:0]  delay_sel_out,
    output logic        led_red_n,
    output logic        led_green_n,
    output logic        scl,
    output logic        sda_oe,
    output logic        usb_rst_n,
    output logic        txd,
    input  logic        sda_in
);

    logic        ram_sel;
    logic        gpio_sel;
    logic        uart_sel;
    logic        ram_ack;
    logic        gpio_ack;
    logic        uart_ready;
    logic [31:0] ram_rdata;
    logic [31:0] gpio_rdata;

    // ---------------------------------------------------------------------
    // Address decode and read return
    // ---------------------------------------------------------------------

    bus_decoder i_bus_decoder (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .ram_ack    (ram_ack),
        .gpio_ack   (gpio_ack),
        .uart_ready (uart_ready),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .ram_sel    (ram_sel),
        .gpio_sel   (gpio_sel),
        .uart_sel   (uart_sel),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .irq        (irq)
    );

    // ---------------------------------------------------------------------
    // Slaves
    // ---------------------------------------------------------------------

    soc_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_soc_ram (
        .clk_rv    (clk_rv),
        .ram_sel   (ram_sel),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .ram_ack   (ram_ack),
        .ram_rdata (ram_rdata)
    );

    gpio_regs i_gpio_regs (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .gpio_sel      (gpio_sel),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .delay_sel_in  (delay_sel_in),
        .sda_in        (sda_in),
        .gpio_ack      (gpio_ack),
        .gpio_rdata    (gpio_rdata),
        .delay_sel_out (delay_sel_out),
        .led_red_n     (led_red_n),
        .led_green_n   (led_green_n),
        .scl           (scl),
        .sda_oe        (sda_oe),
        .usb_rst_n     (usb_rst_n)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .uart_sel   (uart_sel),
        .mem_wdata  (mem_wdata),
        .uart_ready (uart_ready),
        .txd        (txd)
    );

endmodule

/* hw/soc_map_pkg.sv */
package soc_map_pkg;

    // ---------------------------------------------------------------------
    // Bus address views
    // ---------------------------------------------------------------------

    typedef struct packed {
        logic [15:0] page;
        logic [15:0] offset;
    } bus_addr_parts_t;

    // Same word, seen flat or as page plus offset
    typedef union packed {
        logic [31:0]     flat;
        bus_addr_parts_t parts;
    } bus_addr_u;

    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_GPIO,
        REGION_UART,
        REGION_NONE
    } region_e;

    // ---------------------------------------------------------------------
    // Memory map
    // ---------------------------------------------------------------------

    // Internal RAM fills the top page and echoes within it
    localparam logic [15:0] RAM_PAGE = 16'hFFFF;

    localparam logic [15:0] GPIO_PAGE        = 16'h0300;
    localparam logic [15:0] GPIO_LAST_OFFSET = 16'h00FC;

    // Single word, just past the GPIO block
    localparam logic [15:0] UART_OFFSET = 16'h0100;

    // Read value of anything that has no read data
    localparam logic [31:0] BUS_IDLE_DATA = 32'hFFFF_FFFF;

endpackage

/* hw/soc_ram.sv */
`timescale 1ns/1ns

module soc_ram
    import soc_map_pkg::*;
#(
    parameter int RAM_WORDS = 2048
) (
    input  logic        clk_rv,
    input  logic        ram_sel,
    input  bus_addr_u   mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wstrb,
    output logic        ram_ack,
    output logic [31:0] ram_rdata
);

    // RAM_WORDS is a power of two, so the low word bits wrap the page
    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] word_idx;

    assign word_idx = mem_addr.parts.offset[IDX_W+1:2];

    // Byte lanes written independently
    always_ff @(posedge clk_rv) begin
        if (ram_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) begin
                    mem[word_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, old word on a write
    always_ff @(posedge clk_rv) begin
        if (ram_sel) begin
            ram_rdata <= mem[word_idx];
        end
    end

    // Select drops once this is seen, giving a single pulse
    always_ff @(posedge clk_rv) begin
        ram_ack <= ram_sel;
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
    import periph_pkg::*;
#(
    parameter int CLKS_PER_BIT = 217
) (
    input  logic        clk_rv,
    input  logic        rst_rv,
    input  logic        uart_sel,
    input  logic [31:0] mem_wdata,
    output logic        uart_ready,
    output logic        txd
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BIT_W  = $clog2(UART_FRAME_BITS);

    logic [UART_FRAME_BITS-1:0] frame_q;
    logic [BAUD_W-1:0]          baud_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic                       busy;
    logic                       baud_end;

    assign baud_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

    // ---------------------------------------------------------------------
    // Accept and shift
    // ---------------------------------------------------------------------

    // The frame register runs one cycle ahead of txd. busy drops with the
    // stop bit still on the line, so the next ready follows its end
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            frame_q    <= '1;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            busy       <= 1'b0;
            uart_ready <= 1'b0;
            txd        <= UART_STOP_BIT;
        end else begin
            uart_ready <= 1'b0;
            txd        <= frame_q[0];
            if (!busy) begin
                // Reads land here too and send whatever is on the bus
                if (uart_sel) begin
                    frame_q    <= {UART_STOP_BIT, mem_wdata[UART_DATA_W-1:0], UART_START_BIT};
                    baud_cnt   <= '0;
                    bit_cnt    <= '0;
                    busy       <= 1'b1;
                    uart_ready <= 1'b1;
                end
            end else if (baud_end) begin
                baud_cnt <= '0;
                // Fill with idle level, LSB first
                frame_q  <= {1'b1, frame_q[UART_FRAME_BITS-1:1]};
                if (bit_cnt == BIT_W'(UART_FRAME_BITS - 1)) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_soc -f files.f -o tb_soc \
    && ./obj_dir/tb_soc > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
